// ==== files.f ====
source/panel_pkg.sv
source/panel_status_if.sv
source/step_timer.sv
source/serial_tx.sv
source/serial_rx.sv
source/light_shifter.sv
source/display_select.sv
source/panel_top.sv
verification/tb_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the panel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_panel -f files.f
out=$(./obj_dir/Vtb_panel) || true
echo "$out"
echo "$out" | grep -q "Test passed"

// ==== source/display_select.sv ====
// data lamp source select
`timescale 1ns/1ns

module display_select import panel_pkg::*; (
    input  logic clk12,
    input  logic reset,
    input  logic [5:0] dsel,
    input  logic [11:0] sr,
    input  logic [8:0] switches,
    panel_status_if.display status,
    output logic [11:0] ds
);

    logic [11:0] sr_q;
    logic [8:0] switches_q;
    disp_src_t src;

    always_ff @(posedge clk12) begin
        sr_q <= sr;
        switches_q <= switches;
    end

    // lowest select bit wins
    always_comb begin
        if (dsel[0]) src = src_tx_char;
        else if (dsel[1]) src = src_switch_reg;
        else if (dsel[2]) src = src_switches;
        else if (dsel[3] || dsel[4]) src = src_shift_pattern;
        else if (dsel[5]) src = src_rx_char;
        else src = src_hold;
    end

    always_ff @(posedge clk12) begin
        if (reset) begin
            ds <= '0;    // all dsn lamps dark
        end else begin
            case (src)
                src_tx_char: ds <= {4'b0, status.tx_char};
                src_switch_reg: ds <= sr_q;
                src_switches: ds <= {switches_q, 3'b0};
                src_shift_pattern: ds <= status.shift_pattern;
                src_rx_char: ds <= {4'b0, status.rx_char};
                default: ds <= ds;
            endcase
        end
    end

    // shown walking lamp only moves after a step pulse
    shift_lamps_move_on_step: assert property (
        @(posedge clk12) disable iff (reset)
        (src == src_shift_pattern && $past(src) == src_shift_pattern
            && !$past(status.step)) |=> $stable(ds)
    );

endmodule

// ==== source/light_shifter.sv ====
// walking lamp pattern
`timescale 1ns/1ns

module light_shifter (
    input  logic clk12,
    input  logic reset,
    input  logic dsel_left,
    input  logic dsel_right,
    panel_status_if.light_side status
);

    always_ff @(posedge clk12) begin
        if (reset) begin
            status.shift_pattern <= '0;
        end else if (status.step) begin
            if (dsel_right) begin    // right wins when both are on
                if (status.shift_pattern == '0) status.shift_pattern <= 12'o4000;
                else status.shift_pattern <= status.shift_pattern >> 1;
            end else if (dsel_left) begin
                if (status.shift_pattern == '0) status.shift_pattern <= 12'o0001;
                else status.shift_pattern <= {status.shift_pattern[10:0], 1'b0};
            end
        end
    end

    // the lit bit runs off the end and the pattern restarts from zero
    one_lamp_lit: assert property (
        @(posedge clk12) disable iff (reset) $onehot0(status.shift_pattern)
    );

endmodule

// ==== source/panel_pkg.sv ====
// panel exerciser constants and types
package panel_pkg;

    localparam int unsigned clk_hz = 12_000_000;
    localparam int unsigned baud_rate = 115_200;
    localparam int unsigned baud_div = clk_hz / baud_rate;    // 104 clocks per bit
    localparam int unsigned step_div_default = clk_hz / 2;    // half a second

    localparam int unsigned line_cols = 80;
    localparam logic [7:0] first_char = 8'h20;   // space
    localparam logic [7:0] last_char = 8'h7e;    // tilde

    // counter wide enough for one bit time, shared by both serial blocks
    typedef logic [$clog2(baud_div)-1:0] baud_cnt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    typedef enum logic [2:0] {
        src_tx_char,
        src_switch_reg,
        src_switches,
        src_shift_pattern,
        src_rx_char,
        src_hold
    } disp_src_t;

endpackage

// ==== source/panel_status_if.sv ====
// panel status bundle
`timescale 1ns/1ns

interface panel_status_if;

    logic [7:0] tx_char;         // character of the frame on the tx pin
    logic [7:0] rx_char;         // last good character received
    logic [11:0] shift_pattern;  // walking lamp
    logic step;                  // one-cycle step pulse

    modport tx_side (output tx_char);
    modport rx_side (output rx_char);
    modport light_side (output shift_pattern, input step);
    modport timer_side (output step);

    // the data lamp selector looks at everything
    modport display (input tx_char, input rx_char, input shift_pattern, input step);

endinterface

// ==== source/panel_top.sv ====
// front panel exerciser top level
`timescale 1ns/1ns

module panel_top import panel_pkg::*; #(
    parameter int unsigned step_div = step_div_default
) (
    input  logic clk12,
    input  logic reset,
    input  logic rx,
    input  logic [11:0] sr,
    input  logic [5:0] dsel,
    input  logic dep,
    input  logic sw,
    input  logic single_step,
    input  logic halt,
    input  logic examn,
    input  logic contn,
    input  logic extd_addrn,
    input  logic addr_loadn,
    input  logic clearn,
    output logic tx,
    output logic runn,
    output logic [2:0] eman,
    output logic [11:0] an,
    output logic [11:0] dsn
);

    panel_status_if status ();

    logic [14:0] address;
    logic [11:0] ds;
    logic [8:0] switches;

    // active-low switches shown as pressed = 1
    assign switches = {sw, ~addr_loadn, ~extd_addrn, ~clearn, ~contn,
                       ~examn, halt, single_step, dep};

    assign {eman, an} = ~address;
    assign dsn = ~ds;
    assign runn = rx;    // run lamp lit while rx is low

    step_timer #(.step_div(step_div)) u_step_timer (
        .clk12   (clk12),
        .reset   (reset),
        .status  (status.timer_side),
        .address (address)
    );

    serial_tx u_serial_tx (
        .clk12  (clk12),
        .reset  (reset),
        .status (status.tx_side),
        .tx     (tx)
    );

    serial_rx u_serial_rx (
        .clk12  (clk12),
        .reset  (reset),
        .rx     (rx),
        .status (status.rx_side)
    );

    light_shifter u_light_shifter (
        .clk12      (clk12),
        .reset      (reset),
        .dsel_left  (dsel[3]),
        .dsel_right (dsel[4]),
        .status     (status.light_side)
    );

    display_select u_display_select (
        .clk12    (clk12),
        .reset    (reset),
        .dsel     (dsel),
        .sr       (sr),
        .switches (switches),
        .status   (status.display),
        .ds       (ds)
    );

endmodule

// ==== source/serial_rx.sv ====
// serial 8N1 receiver
`timescale 1ns/1ns

module serial_rx import panel_pkg::*; (
    input  logic clk12,
    input  logic reset,
    input  logic rx,
    panel_status_if.rx_side status
);

    logic rx_meta;
    logic rx_sync;
    logic busy;
    logic [3:0] bit_idx;    // 0 start, 1..8 data, 9 stop, 10 wait for line high
    baud_cnt_t baud_cnt;
    logic [7:0] shift;

    // two flop synchronizer
    always_ff @(posedge clk12) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk12) begin
        if (reset) begin
            busy <= 1'b0;
            bit_idx <= '0;
            baud_cnt <= '0;
            status.rx_char <= '0;
        end else if (!busy) begin
            if (!rx_sync) begin    // line low, possible start bit
                busy <= 1'b1;
                bit_idx <= '0;
                baud_cnt <= '0;
            end
        end else if (bit_idx == 4'd10) begin
            if (rx_sync) busy <= 1'b0;   // framing error cleared
        end else if (bit_idx == 4'd0) begin
            if (baud_cnt == baud_cnt_t'(baud_div / 2 - 1)) begin
                baud_cnt <= '0;
                if (rx_sync) begin
                    busy <= 1'b0;    // glitch, not a start bit
                end else begin
                    bit_idx <= 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end else if (baud_cnt == baud_cnt_t'(baud_div - 1)) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9) begin
                if (rx_sync) begin
                    status.rx_char <= shift;
                    busy <= 1'b0;
                end else begin
                    bit_idx <= 4'd10;   // low stop bit, frame dropped
                end
            end else begin
                shift <= {rx_sync, shift[7:1]};
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== source/serial_tx.sv ====
// serial test text transmitter
`timescale 1ns/1ns

module serial_tx import panel_pkg::*; (
    input  logic clk12,
    input  logic reset,
    panel_status_if.tx_side status,
    output logic tx
);

    tx_state_t state;
    baud_cnt_t baud_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic [7:0] seq_char;    // next printable character
    logic [6:0] col_cnt;     // 0..79 printable, then cr, then lf
    logic [7:0] frame_char;
    logic baud_last;
    logic load;

    assign baud_last = (baud_cnt == baud_cnt_t'(baud_div - 1));

    // a new frame starts right out of reset and after every stop bit
    assign load = (state == st_idle) || (state == st_stop && baud_last);

    always_comb begin
        if (col_cnt < 7'(line_cols)) begin
            frame_char = seq_char;
        end else if (col_cnt == 7'(line_cols)) begin
            frame_char = 8'h0d;
        end else begin
            frame_char = 8'h0a;
        end
    end

    always_ff @(posedge clk12) begin
        if (reset) begin
            state <= st_idle;
            tx <= 1'b1;           // line idles high
            baud_cnt <= '0;
            bit_idx <= '0;
            seq_char <= first_char;
            col_cnt <= '0;
            status.tx_char <= '0;
        end else if (load) begin
            state <= st_start;
            tx <= 1'b0;           // start bit
            baud_cnt <= '0;
            shift <= frame_char;
            status.tx_char <= frame_char;
            if (col_cnt < 7'(line_cols)) begin
                seq_char <= (seq_char == last_char) ? first_char : seq_char + 8'd1;
                col_cnt <= col_cnt + 7'd1;
            end else if (col_cnt == 7'(line_cols)) begin
                col_cnt <= col_cnt + 7'd1;
            end else begin
                col_cnt <= '0;    // lf done, new line
            end
        end else if (!baud_last) begin
            baud_cnt <= baud_cnt + 1'b1;
        end else begin
            baud_cnt <= '0;
            case (state)
                st_start: begin
                    state <= st_data;
                    tx <= shift[0];   // lsb first
                    shift <= shift >> 1;
                    bit_idx <= '0;
                end
                st_data: begin
                    if (bit_idx == 3'd7) begin
                        state <= st_stop;
                        tx <= 1'b1;
                    end else begin
                        tx <= shift[0];
                        shift <= shift >> 1;
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    tx_high_when_not_framing: assert property (
        @(posedge clk12) disable iff (reset) (state == st_idle || state == st_stop) |-> tx
    );

endmodule

// ==== source/step_timer.sv ====
// step timer and lamp address
`timescale 1ns/1ns

module step_timer import panel_pkg::*; #(
    parameter int unsigned step_div = step_div_default
) (
    input  logic clk12,
    input  logic reset,
    panel_status_if.timer_side status,
    output logic [14:0] address
);

    typedef logic [$clog2(step_div)-1:0] count_t;

    count_t count;   // clocks left until the next step

    always_ff @(posedge clk12) begin
        if (reset) begin
            count <= count_t'(step_div - 1);
            status.step <= 1'b0;
        end else if (count == '0) begin
            count <= count_t'(step_div - 1);
            status.step <= 1'b1;
        end else begin
            count <= count - 1'b1;
            status.step <= 1'b0;
        end
    end

    // address lamps count the steps
    always_ff @(posedge clk12) begin
        if (reset) begin
            address <= '0;
        end else if (status.step) begin
            address <= address + 15'd1;
        end
    end

    step_single_cycle: assert property (
        @(posedge clk12) disable iff (reset) status.step |=> !status.step
    );

endmodule

// ==== verification/tb_panel.sv ====
// front panel exerciser testbench
`timescale 1ns/1ns

module tb_panel import panel_pkg::*; ();

    localparam int unsigned step_cycles = 64;    // short step period for simulation
    localparam logic [31:0] lfsr_seed = 32'hc10f_a624;

    logic clk12;
    logic reset;
    logic rx;
    logic [11:0] sr;
    logic [5:0] dsel;
    logic dep, sw, single_step, halt;
    logic examn, contn, extd_addrn, addr_loadn, clearn;
    logic tx;
    logic runn;
    logic [2:0] eman;
    logic [11:0] an;
    logic [11:0] dsn;

    logic [31:0] lfsr;
    int unsigned cyc;    // clocks since reset release

    panel_top #(.step_div(step_cycles)) u_dut (.*);

    initial begin
        clk12 = 1'b0;
        forever #10 clk12 = ~clk12;
    end

    always @(posedge clk12) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // lamps are lit low
    function automatic logic [11:0] active_low(input logic [11:0] v);
        return ~v;
    endfunction

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk12);
            #2;    // inputs change and outputs are read away from the edge
        end
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic give_up(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping after a timeout");
    endtask

    task automatic wait_start_bit();
        int n;
        n = 0;
        while (tx !== 1'b0) begin
            if (n > 2 * baud_div) give_up("no start bit was seen on tx");
            else tick(1);
            n++;
        end
    endtask

    task automatic wait_step_phase(input int unsigned off);
        int n;
        n = 0;
        do begin
            if (n > step_cycles) give_up("the step period boundary was never reached");
            else tick(1);
            n++;
        end while (cyc % step_cycles != off);
    endtask

    task automatic send_bit(input logic v);
        rx = v;
        repeat (baud_div) begin
            tick(1);
            check_value(rx, runn, "run lamp follows rx");
        end
    endtask

    // one step per period, pattern read at offset 4 after the boundary
    task automatic walk(input logic [5:0] sel, input int steps, inout logic [11:0] pat);
        dsel = sel;
        repeat (steps) begin
            wait_step_phase(4);
            if (sel[4]) pat = (pat == '0) ? 12'o4000 : pat >> 1;
            else pat = (pat == '0) ? 12'o0001 : pat << 1;
            check_value(active_low(pat), dsn, "walking lamp");
        end
    endtask

    initial begin
        logic [7:0] seq;
        logic [7:0] exp_char;
        logic [7:0] got;
        logic [7:0] last_good;
        logic [11:0] pat;
        logic [14:0] exp_addr;
        logic [31:0] r;
        logic stop_ok;
        int col;

        lfsr = lfsr_seed;
        reset = 1'b1;
        rx = 1'b1;
        sr = '0;
        dsel = 6'b000001;    // tx_char on the data lamps
        {sw, addr_loadn, extd_addrn, clearn, contn, examn, halt, single_step, dep} = 9'b011111000;
        repeat (5) @(posedge clk12);
        #2;
        reset = 1'b0;

        // transmitted text, 80 printable then cr lf
        seq = first_char;
        col = 0;
        for (int f = 0; f < 84; f++) begin
            if (col < line_cols) begin
                exp_char = seq;
                seq = (seq == last_char) ? first_char : seq + 8'd1;
                col++;
            end else if (col == line_cols) begin
                exp_char = 8'h0d;
                col++;
            end else begin
                exp_char = 8'h0a;
                col = 0;
            end
            wait_start_bit();
            tick(baud_div / 2);    // middle of the start bit
            check_value(1'b0, tx, "start bit");
            check_value(active_low({4'h0, exp_char}), dsn, "frame character on data lamps");
            for (int b = 0; b < 8; b++) begin
                tick(baud_div);
                got[b] = tx;
            end
            tick(baud_div);
            check_value(1'b1, tx, "stop bit");
            check_value(exp_char, got, "transmitted character");
        end

        // receive path
        dsel = 6'b100000;
        last_good = '0;
        for (int f = 0; f < 12; f++) begin
            rand_bits(8, r);
            exp_char = r[7:0];
            rand_bits(2, r);
            stop_ok = (r[1:0] != 2'b00);    // about one frame in four is bad
            send_bit(1'b0);
            for (int b = 0; b < 8; b++) send_bit(exp_char[b]);
            send_bit(stop_ok);
            send_bit(1'b1);
            if (stop_ok) last_good = exp_char;
            check_value(active_low({4'h0, last_good}), dsn, "received character on data lamps");
        end

        // switch register, then the switch vector
        dsel = 6'b000010;
        repeat (8) begin
            rand_bits(12, r);
            sr = r[11:0];
            tick(3);
            check_value(active_low(r[11:0]), dsn, "switch register on data lamps");
        end
        dsel = 6'b000100;
        repeat (8) begin
            rand_bits(9, r);
            {sw, addr_loadn, extd_addrn, clearn, contn, examn, halt, single_step, dep} = r[8:0];
            tick(3);
            check_value(active_low({r[8], ~r[7:3], r[2:0], 3'b000}), dsn,
                        "switches on data lamps");
        end

        // step counter on the address lamps
        for (int i = 0; i < 20; i++) begin
            wait_step_phase(2);
            exp_addr = ~15'(cyc / step_cycles);
            check_value(exp_addr, {eman, an}, "step count on address lamps");
        end

        pat = '0;
        wait_step_phase(4);
        walk(6'b001000, 14, pat);    // left
        walk(6'b010000, 14, pat);    // right
        walk(6'b011000, 6, pat);     // right wins

        $display("Test passed");
        $finish;
    end

endmodule
